//--- Bender.yml
package:
  name: sad_trigger

sources:
  - common/sad_pkg.sv
  - sad_engine/sad_history_fifo.sv
  - sad_engine/sad_lane.sv
  - sad_engine/sad_engine.sv
  - hw/sad_regs.sv
  - hw/sad_control.sv
  - hw/sad_trigger_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/sad_tb.sv

//--- build.f
common/sad_pkg.sv
sad_engine/sad_history_fifo.sv
sad_engine/sad_lane.sv
sad_engine/sad_engine.sv
hw/sad_regs.sv
hw/sad_control.sv
hw/sad_trigger_top.sv
dv/tb_clock_gen.sv
dv/sad_tb.sv

//--- common/sad_pkg.sv
package sad_pkg;

    localparam int SAMPLE_BITS     = 8;
    localparam int REF_SAMPLES_MAX = 32;

    // one adc sample, also one absolute difference
    typedef logic [SAMPLE_BITS-1:0] sample_t;

    // holds REF_SAMPLES_MAX differences of full scale
    typedef logic [$clog2(REF_SAMPLES_MAX*((1 << SAMPLE_BITS) - 1) + 1)-1:0] sad_sum_t;

    typedef logic [15:0] threshold_t;   // two register bytes

    // position within the window
    typedef logic [$clog2(REF_SAMPLES_MAX)-1:0] ref_index_t;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_byte_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_INITIALIZING,
        S_RUNNING,
        S_FLUSH
    } sad_state_e;

    // register map
    localparam reg_addr_t ADDR_REFERENCE         = 8'h30;
    localparam reg_addr_t ADDR_THRESHOLD         = 8'h31;
    localparam reg_addr_t ADDR_STATUS            = 8'h32;  // bit 0 triggered, write clears
    localparam reg_addr_t ADDR_BITS_PER_SAMPLE   = 8'h33;  // read only
    localparam reg_addr_t ADDR_REF_SAMPLES       = 8'h34;  // read only
    localparam reg_addr_t ADDR_MULTIPLE_TRIGGERS = 8'h35;

endpackage

//--- dv/sad_tb.sv
`timescale 1ns/1ps

module sad_tb import sad_pkg::*; ();

    localparam int REF_LEN         = 32;
    localparam int DRIVE_DELAY     = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int RUN_LEN         = 400;          // samples per run
    localparam int RUN_TAIL        = 40;           // setup, flush and rearm around a run
    localparam int REG_CYCLES      = 160;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + REG_CYCLES + 4 * (RUN_LEN + RUN_TAIL);
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES * 6 / 5;
    localparam threshold_t MATCH_THR = 16'd48;     // planted copies stay at or below 32

    logic       adc_sampleclk;
    logic       reset;
    sample_t    adc_datain;
    logic       armed_and_ready;
    logic       active;
    reg_addr_t  reg_address;
    logic [6:0] reg_bytecnt;
    reg_byte_t  reg_datai;
    reg_byte_t  reg_datao;
    logic       reg_read;
    logic       reg_write;
    logic       trigger;

    sample_t ref_model [REF_LEN];
    sample_t stim [RUN_LEN];
    logic    exp_trig [RUN_LEN + 8];   // indexed by cycle after edge E
    int      exp_count;
    int      fired_count;
    int      errors;
    int      errors_at_start;
    int      tests_run;
    int      tests_failed;

    tb_clock_gen #(.period_ns(100)) u_clock_gen (.adc_sampleclk(adc_sampleclk));

    sad_trigger_top #(
        .ref_samples (REF_LEN)
    ) u_sad_trigger_top (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .reg_address     (reg_address),
        .reg_bytecnt     (reg_bytecnt),
        .reg_datai       (reg_datai),
        .reg_datao       (reg_datao),
        .reg_read        (reg_read),
        .reg_write       (reg_write),
        .trigger         (trigger)
    );

    task automatic next_cycle();
        @(posedge adc_sampleclk);
        #DRIVE_DELAY;
    endtask

    task automatic check_trigger(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error at %0t: trigger got %b expected %b", $time, actual, expected);
            errors++;
        end
    endtask

    task automatic check_reg_byte(input string name, input reg_byte_t actual,
                                  input reg_byte_t expected);
        if (actual !== expected) begin
            $display("error at %0t: %s got %h expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_sum_state(input string name, input threshold_t actual,
                                   input threshold_t expected);
        if (actual !== expected) begin
            $display("error at %0t: %s got %h expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [6:0] cnt, input reg_byte_t data);
        next_cycle();
        reg_address = addr;
        reg_bytecnt = cnt;
        reg_datai   = data;
        reg_write   = 1'b1;
        next_cycle();
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, input logic [6:0] cnt, output reg_byte_t data);
        next_cycle();
        reg_address = addr;
        reg_bytecnt = cnt;
        reg_read    = 1'b1;
        #50;                       // mid cycle, mux output settled
        data = reg_datao;
        next_cycle();
        reg_read = 1'b0;
    endtask

    task automatic set_threshold(input threshold_t thr);
        write_reg(ADDR_THRESHOLD, 7'd0, thr[7:0]);
        write_reg(ADDR_THRESHOLD, 7'd1, thr[15:8]);
    endtask

    function automatic int window_sad(input int last);
        int sad;
        int d;
        int i;
        sad = 0;
        for (i = 0; i < REF_LEN; i++) begin
            d = int'(stim[last - REF_LEN + 1 + i]) - int'(ref_model[i]);
            sad += (d < 0) ? -d : d;
        end
        return sad;
    endfunction

    task automatic fill_noise();
        int i;
        for (i = 0; i < RUN_LEN; i++)
            stim[i] = sample_t'($urandom);
    endtask

    // reference copy with an offset of -1, 0 or +1 per sample
    task automatic plant_copy(input int start);
        int v;
        int i;
        for (i = 0; i < REF_LEN; i++) begin
            v = int'(ref_model[i]) + int'($urandom_range(2)) - 1;
            stim[start + i] = sample_t'((v < 0) ? 0 : ((v > 255) ? 255 : v));
        end
    endtask

    task automatic run_window(input logic multi, input threshold_t thr);
        int j;
        int m;
        exp_count   = 0;
        fired_count = 0;
        for (m = 0; m < RUN_LEN + 8; m++)
            exp_trig[m] = 1'b0;
        // windows ending in the last few samples are left out
        for (j = REF_LEN - 1; j <= RUN_LEN - 6; j++) begin
            if (window_sad(j) <= int'(thr) && (multi || exp_count == 0)) begin
                exp_trig[j + 6] = 1'b1;   // sampled on E+1+j, five cycles of latency
                exp_count++;
            end
        end
        next_cycle();
        armed_and_ready = 1'b1;
        active          = 1'b1;
        adc_datain      = sample_t'($urandom);
        next_cycle();                     // control leaves idle on this edge
        for (m = 0; m < RUN_LEN + 8; m++) begin
            adc_datain = (m < RUN_LEN) ? stim[m] : sample_t'($urandom);
            active     = (m < RUN_LEN);
            if (m <= RUN_LEN || (!multi && exp_count > 0))
                check_trigger(trigger, exp_trig[m]);
            fired_count += int'(trigger);
            next_cycle();
        end
        armed_and_ready = 1'b0;
        next_cycle();
        next_cycle();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errors_at_start)
            tests_failed++;
        $display("test %-10s %s", name, (errors == errors_at_start) ? "passed" : "failed");
        errors_at_start = errors;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge adc_sampleclk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        reg_byte_t  rd;
        reg_byte_t  hi;
        threshold_t thr;
        int         i;
        void'($urandom(32'h8cf8_3d91));
        reset           = 1'b1;
        adc_datain      = '0;
        armed_and_ready = 1'b0;
        active          = 1'b0;
        reg_address     = '0;
        reg_bytecnt     = '0;
        reg_datai       = '0;
        reg_read        = 1'b0;
        reg_write       = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (RESET_CYCLES) @(posedge adc_sampleclk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // register readback
        for (i = 0; i < REF_LEN; i++) begin
            ref_model[i] = sample_t'($urandom);
            write_reg(ADDR_REFERENCE, 7'(i), ref_model[i]);
        end
        thr = threshold_t'($urandom);
        set_threshold(thr);
        for (i = 0; i < REF_LEN; i++) begin
            read_reg(ADDR_REFERENCE, 7'(i), rd);
            check_reg_byte("reference", rd, ref_model[i]);
        end
        read_reg(ADDR_THRESHOLD, 7'd0, rd);
        read_reg(ADDR_THRESHOLD, 7'd1, hi);
        check_sum_state("threshold", {hi, rd}, thr);
        read_reg(ADDR_BITS_PER_SAMPLE, 7'd0, rd);
        check_reg_byte("bits_per_sample", rd, 8'd8);
        read_reg(ADDR_REF_SAMPLES, 7'd0, rd);
        check_reg_byte("ref_samples", rd, 8'd32);
        read_reg(8'h36, 7'd0, rd);
        check_reg_byte("unused_36", rd, 8'd0);
        read_reg(8'h00, 7'd0, rd);
        check_reg_byte("unused_00", rd, 8'd0);
        finish_test("regs");

        // single trigger
        fill_noise();
        plant_copy(40 + int'($urandom_range(60)));
        plant_copy(200 + int'($urandom_range(100)));
        set_threshold(MATCH_THR);
        write_reg(ADDR_MULTIPLE_TRIGGERS, 7'd0, 8'd0);
        run_window(1'b0, MATCH_THR);
        if (exp_count != 1)
            report_problem("single trigger run has no qualifying window in its stimulus");
        if (fired_count != 1)
            report_problem($sformatf("single trigger run gave %0d pulses, not one", fired_count));
        finish_test("single");

        // sticky status, clear, then rearm for a new run
        read_reg(ADDR_STATUS, 7'd0, rd);
        check_reg_byte("status", rd, 8'd1);
        write_reg(ADDR_STATUS, 7'd0, 8'd1);
        read_reg(ADDR_STATUS, 7'd0, rd);
        check_reg_byte("status", rd, 8'd0);
        fill_noise();
        plant_copy(100 + int'($urandom_range(150)));
        run_window(1'b0, MATCH_THR);
        if (fired_count != 1)
            report_problem("run after status clear and rearm did not trigger once");
        read_reg(ADDR_STATUS, 7'd0, rd);
        check_reg_byte("status", rd, 8'd1);
        finish_test("status");

        // multiple triggers
        fill_noise();
        for (i = 0; i < 4; i++)
            plant_copy(40 + 80 * i + int'($urandom_range(30)));
        write_reg(ADDR_MULTIPLE_TRIGGERS, 7'd0, 8'd1);
        run_window(1'b1, MATCH_THR);
        if (exp_count < 4)
            report_problem("multiple trigger run has fewer than four qualifying windows");
        finish_test("multiple");

        // exact match needed, plain noise never gives one
        fill_noise();
        set_threshold(16'd0);
        run_window(1'b1, 16'd0);
        if (exp_count != 0)
            report_problem("noise repeated the reference exactly, no-match run is invalid");
        if (fired_count != 0)
            report_problem("trigger fired during the no-match run");
        finish_test("no_match");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns = 100
) (
    output logic adc_sampleclk
);

    initial begin
        adc_sampleclk = 1'b0;
        forever #(period_ns / 2) adc_sampleclk = ~adc_sampleclk;
    end

endmodule

//--- hw/sad_control.sv
`timescale 1ns/1ps

module sad_control import sad_pkg::*; #(
    parameter int ref_samples = 32
) (
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  logic                   armed_and_ready,
    input  logic                   active,
    input  logic                   multiple_triggers,
    input  logic                   status_clear,
    input  logic                   window_match,
    output logic [ref_samples-1:0] lane_enable,
    output logic                   trigger,
    output logic                   triggered
);

    localparam ref_index_t LAST_LANE = ref_index_t'(ref_samples - 1);

    sad_state_e state;
    ref_index_t start_cnt;  // next lane to start

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state       <= S_IDLE;
            start_cnt   <= '0;
            lane_enable <= '0;
            trigger     <= 1'b0;
        end else begin
            trigger <= 1'b0;
            case (state)
                S_IDLE: begin
                    start_cnt   <= '0;
                    lane_enable <= '0;
                    if (armed_and_ready && active)
                        state <= S_INITIALIZING;
                end

                // lanes start one per cycle, each one sample later than the last
                S_INITIALIZING: begin
                    lane_enable[start_cnt] <= 1'b1;
                    start_cnt <= start_cnt + 1'b1;
                    if (start_cnt == LAST_LANE)
                        state <= S_RUNNING;
                end

                S_RUNNING: begin
                    if (!active) begin
                        lane_enable <= '0;
                        state       <= S_FLUSH;
                    end else if (armed_and_ready && window_match) begin
                        trigger <= 1'b1;
                        if (!multiple_triggers) begin  // single shot, stop here
                            lane_enable <= '0;
                            state       <= S_FLUSH;
                        end
                    end
                end

                S_FLUSH: begin
                    lane_enable <= '0;
                    // wait for rearm or a status clear
                    if (!armed_and_ready || status_clear)
                        state <= S_IDLE;
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    // sticky until software writes the status register
    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            triggered <= 1'b0;
        else if (status_clear)
            triggered <= 1'b0;
        else if (trigger)
            triggered <= 1'b1;
    end

endmodule

//--- hw/sad_regs.sv
`timescale 1ns/1ps

module sad_regs import sad_pkg::*; #(
    parameter int ref_samples = 32
) (
    input  logic                              adc_sampleclk,
    input  logic                              reset,
    input  reg_addr_t                         reg_address,
    input  logic [6:0]                        reg_bytecnt,
    input  reg_byte_t                         reg_datai,
    input  logic                              reg_read,
    input  logic                              reg_write,
    output reg_byte_t                         reg_datao,
    output sample_t [REF_SAMPLES_MAX-1:0]     reference_flat,
    output threshold_t                        threshold,
    output logic                              multiple_triggers,
    output logic                              status_clear,
    input  logic                              triggered
);

    logic ref_byte_ok;
    logic thr_byte_ok;

    // one byte per reference sample, two threshold bytes
    assign ref_byte_ok = (reg_bytecnt < ref_samples);
    assign thr_byte_ok = (reg_bytecnt < 7'd2);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            reference_flat    <= '0;
            threshold         <= '0;
            multiple_triggers <= 1'b0;
            status_clear      <= 1'b0;
        end else begin
            status_clear <= reg_write && (reg_address == ADDR_STATUS);
            if (reg_write) begin
                case (reg_address)
                    ADDR_REFERENCE: begin
                        if (ref_byte_ok)
                            reference_flat[ref_index_t'(reg_bytecnt)] <= reg_datai;
                    end
                    ADDR_THRESHOLD: begin
                        if (thr_byte_ok)
                            threshold[8*reg_bytecnt[0] +: 8] <= reg_datai;
                    end
                    ADDR_MULTIPLE_TRIGGERS: multiple_triggers <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    // read mux, zero when no read is in progress
    always_comb begin
        reg_datao = '0;
        if (reg_read) begin
            case (reg_address)
                ADDR_REFERENCE: begin
                    if (ref_byte_ok)
                        reg_datao = reference_flat[ref_index_t'(reg_bytecnt)];
                end
                ADDR_THRESHOLD: begin
                    if (thr_byte_ok)
                        reg_datao = threshold[8*reg_bytecnt[0] +: 8];
                end
                ADDR_STATUS:            reg_datao = {7'b0, triggered};
                ADDR_BITS_PER_SAMPLE:   reg_datao = reg_byte_t'(SAMPLE_BITS);
                ADDR_REF_SAMPLES:       reg_datao = reg_byte_t'(ref_samples);
                ADDR_MULTIPLE_TRIGGERS: reg_datao = {7'b0, multiple_triggers};
                default:                reg_datao = '0;
            endcase
        end
    end

endmodule

//--- hw/sad_trigger_top.sv
`timescale 1ns/1ps

module sad_trigger_top import sad_pkg::*; #(
    parameter int ref_samples = 32  // window length, 4 to 32
) (
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  sample_t    adc_datain,
    input  logic       armed_and_ready,
    input  logic       active,
    input  reg_addr_t  reg_address,
    input  logic [6:0] reg_bytecnt,
    input  reg_byte_t  reg_datai,
    output reg_byte_t  reg_datao,
    input  logic       reg_read,
    input  logic       reg_write,
    output logic       trigger
);

    sample_t [REF_SAMPLES_MAX-1:0] reference_flat;
    threshold_t                    threshold;
    logic                          multiple_triggers;
    logic                          status_clear;
    logic                          triggered;
    logic [ref_samples-1:0]        lane_enable;
    logic                          window_match;

    sad_regs #(
        .ref_samples (ref_samples)
    ) u_regs (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .reg_address       (reg_address),
        .reg_bytecnt       (reg_bytecnt),
        .reg_datai         (reg_datai),
        .reg_read          (reg_read),
        .reg_write         (reg_write),
        .reg_datao         (reg_datao),
        .reference_flat    (reference_flat),
        .threshold         (threshold),
        .multiple_triggers (multiple_triggers),
        .status_clear      (status_clear),
        .triggered         (triggered)
    );

    sad_control #(
        .ref_samples (ref_samples)
    ) u_control (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .armed_and_ready   (armed_and_ready),
        .active            (active),
        .multiple_triggers (multiple_triggers),
        .status_clear      (status_clear),
        .window_match      (window_match),
        .lane_enable       (lane_enable),
        .trigger           (trigger),
        .triggered         (triggered)
    );

    sad_engine #(
        .ref_samples (ref_samples)
    ) u_engine (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_datain     (adc_datain),
        .reference_flat (reference_flat),
        .threshold      (threshold),
        .lane_enable    (lane_enable),
        .window_match   (window_match)
    );

endmodule

//--- sad_engine/sad_engine.sv
`timescale 1ns/1ps

module sad_engine import sad_pkg::*; #(
    parameter int ref_samples = 32
) (
    input  logic                          adc_sampleclk,
    input  logic                          reset,
    input  sample_t                       adc_datain,
    input  sample_t [REF_SAMPLES_MAX-1:0] reference_flat,
    input  threshold_t                    threshold,
    input  logic [ref_samples-1:0]        lane_enable,
    output logic                          window_match
);

    sample_t                sample_r;    // shared by every lane
    logic [ref_samples-1:0] lane_match;

    always_ff @(posedge adc_sampleclk) begin
        sample_r <= adc_datain;
    end

    // lane k handles the windows that start at sample k, k+ref_samples, ...
    for (genvar k = 0; k < ref_samples; k++) begin : gen_lane
        sad_lane #(
            .ref_samples (ref_samples)
        ) u_lane (
            .adc_sampleclk  (adc_sampleclk),
            .reset          (reset),
            .enable         (lane_enable[k]),
            .sample         (sample_r),
            .reference_flat (reference_flat),
            .threshold      (threshold),
            .match          (lane_match[k])
        );
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            window_match <= 1'b0;
        else
            window_match <= |lane_match;  // at most one lane ends a window per cycle
    end

endmodule

//--- sad_engine/sad_history_fifo.sv
`timescale 1ns/1ps

module sad_history_fifo import sad_pkg::*; #(
    parameter int ref_samples = 32
) (
    input  logic    adc_sampleclk,
    input  logic    reset,
    input  logic    clear,
    input  logic    wr_en,
    input  sample_t wr_data,
    input  logic    rd_en,
    output sample_t rd_data
);

    localparam ref_index_t LAST_SLOT = ref_index_t'(ref_samples - 1);

    sample_t    mem [ref_samples];
    ref_index_t wr_ptr;
    ref_index_t rd_ptr;

    function automatic ref_index_t next_ptr(input ref_index_t ptr);
        next_ptr = (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;  // depth need not be a power of two
    endfunction

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (rd_en)
                rd_ptr <= next_ptr(rd_ptr);
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (wr_en && !clear)
            mem[wr_ptr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_ptr];  // registered read, no fall-through
    end

endmodule

//--- sad_engine/sad_lane.sv
`timescale 1ns/1ps

module sad_lane import sad_pkg::*; #(
    parameter int ref_samples = 32
) (
    input  logic                          adc_sampleclk,
    input  logic                          reset,
    input  logic                          enable,
    input  sample_t                       sample,
    input  sample_t [REF_SAMPLES_MAX-1:0] reference_flat,
    input  threshold_t                    threshold,
    output logic                          match
);

    localparam ref_index_t LAST_INDEX = ref_index_t'(ref_samples - 1);

    ref_index_t ref_index;
    logic       wrapped;      // first window done, start retiring
    sample_t    ref_sample;
    logic       retire_rd;

    sample_t    diff;
    logic       diff_valid;
    logic       diff_last;
    logic       diff_retire;
    sample_t    retired;      // difference leaving the window

    sad_sum_t   sum;
    logic       sum_last;

    assign ref_sample = reference_flat[ref_index];
    assign retire_rd  = enable && wrapped;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !enable) begin
            ref_index <= '0;
            wrapped   <= 1'b0;
        end else if (ref_index == LAST_INDEX) begin
            ref_index <= '0;
            wrapped   <= 1'b1;
        end else begin
            ref_index <= ref_index + 1'b1;
        end
    end

    // difference stage
    always_ff @(posedge adc_sampleclk) begin
        if (sample > ref_sample)
            diff <= sample - ref_sample;
        else
            diff <= ref_sample - sample;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            diff_valid  <= 1'b0;
            diff_last   <= 1'b0;
            diff_retire <= 1'b0;
            sum_last    <= 1'b0;
            match       <= 1'b0;
        end else begin
            diff_valid  <= enable;
            diff_last   <= enable && (ref_index == LAST_INDEX);
            diff_retire <= retire_rd;
            sum_last    <= diff_last;
            // compare only when the sum covers a whole aligned window
            match       <= sum_last && (threshold_t'(sum) <= threshold);
        end
    end

    // accumulate stage, modulo arithmetic keeps the final sum exact
    always_ff @(posedge adc_sampleclk) begin
        if (!diff_valid)
            sum <= '0;
        else if (diff_retire)
            sum <= sum + sad_sum_t'(diff) - sad_sum_t'(retired);
        else
            sum <= sum + sad_sum_t'(diff);
    end

    sad_history_fifo #(
        .ref_samples (ref_samples)
    ) u_history (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear         (!enable),
        .wr_en         (diff_valid),
        .wr_data       (diff),
        .rd_en         (retire_rd),
        .rd_data       (retired)
    );

endmodule
